// File: hdl/dm_pkg.sv
package dm_pkg;

    // DMI request and response words are {addr, data[31:0], op/status[1:0]}
    localparam int ABITS = 7;
    localparam int DMI_W = ABITS + 32 + 2;

    localparam logic [1:0] OP_NOP   = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;
    localparam logic [1:0] OP_RSVD  = 2'd3;

    localparam logic [1:0] RESP_OK   = 2'd0;
    localparam logic [1:0] RESP_FAIL = 2'd2;

    localparam logic [ABITS-1:0] ADDR_DMCONTROL = 7'h10;
    localparam logic [ABITS-1:0] ADDR_DMSTATUS  = 7'h11;

    localparam logic [3:0] DM_VERSION = 4'd2; // debug spec 0.13

    // op-decode states of the intake FSM
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_DECODE = 2'd1;
    localparam logic [1:0] ST_READ   = 2'd2;
    localparam logic [1:0] ST_WRITE  = 2'd3;

    typedef logic [ABITS-1:0] dmi_addr_t;

    // only the dmcontrol fields this debug module implements are named
    typedef struct packed {
        logic        haltreq;      // 31
        logic        rsvd_30;
        logic        hartreset;    // 29
        logic        ackhavereset; // 28
        logic [25:0] rsvd_27_2;
        logic        ndmreset;     // 1
        logic        dmactive;     // 0
    } dmcontrol_t;

    // request data is echoed raw and also taken apart as dmcontrol fields
    typedef union packed {
        logic [31:0] raw;
        dmcontrol_t  ctrl;
    } dm_word_u;

endpackage

// File: hdl/dm_reg_if.sv
`timescale 1ns/1ns

interface dm_reg_if import dm_pkg::*; ();

    logic      wen;
    logic      ren;
    logic      idle_op; // nop or reserved op, no register access
    dmi_addr_t addr;
    dm_word_u  wdata;
    logic [31:0] rdata;
    logic      ok;

    modport intake (
        output wen, ren, idle_op, addr, wdata
    );

    modport regs (
        input  wen, ren, addr, wdata,
        output rdata, ok
    );

    modport resp (
        input wen, ren, idle_op, addr, wdata, rdata, ok
    );

endinterface

// File: hdl/dmi_intake.sv
`timescale 1ns/1ns

module dmi_intake import dm_pkg::*; (
    input  logic             dm_clk,
    input  logic             dm_rst_n,
    input  logic             dtm2dm_empty,
    input  logic [DMI_W-1:0] dtm2dm_data_out,
    output logic             dtm2dm_ren,
    dm_reg_if.intake         reg_bus
);

    logic [1:0]       state;
    logic [DMI_W-1:0] req_q;
    logic [1:0]       req_op;

    assign req_op = req_q[1:0];

    // a single pop per request, and only while nothing is in flight
    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            dtm2dm_ren <= 1'b0;
        end else begin
            dtm2dm_ren <= (state == ST_IDLE) && !dtm2dm_ren && !dtm2dm_empty;
        end
    end

    // the FIFO is first-word fall-through, so the word is valid at the pop edge
    always_ff @(posedge dm_clk) begin
        if (dtm2dm_ren) begin
            req_q <= dtm2dm_data_out;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dtm2dm_ren) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    case (req_op)
                        OP_READ:  state <= ST_READ;
                        OP_WRITE: state <= ST_WRITE;
                        default:  state <= ST_IDLE; // nop and reserved end here
                    endcase
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign reg_bus.addr    = req_q[DMI_W-1 -: ABITS];
    assign reg_bus.wdata   = dm_word_u'(req_q[2 +: 32]);
    assign reg_bus.ren     = (state == ST_READ);
    assign reg_bus.wen     = (state == ST_WRITE);
    assign reg_bus.idle_op = (state == ST_DECODE) && (req_op == OP_NOP || req_op == OP_RSVD);

    // the pop is decided a cycle early, so the FIFO must still hold a word when it lands
    a_pop_not_empty: assert property (
        @(posedge dm_clk) disable iff (!dm_rst_n)
        $rose(dtm2dm_ren) |-> !dtm2dm_empty
    ) else $error("request FIFO popped while empty");

endmodule

// File: hdl/dm_regs.sv
`timescale 1ns/1ns

module dm_regs import dm_pkg::*; (
    input  logic   dm_clk,
    input  logic   dm_rst_n,
    input  logic   dm_core_rst_n,
    output logic   halt_req,
    output logic   hartreset,
    output logic   ndmreset,
    dm_reg_if.regs reg_bus
);

    logic        sel_control;
    logic        sel_status;
    logic        control_wen;
    logic        dmactive;
    logic        havereset;
    dmcontrol_t  wr_ctrl;
    dmcontrol_t  control_rd;
    logic [31:0] status_rd;

    assign wr_ctrl     = reg_bus.wdata.ctrl;
    assign sel_control = (reg_bus.addr == ADDR_DMCONTROL);
    assign sel_status  = (reg_bus.addr == ADDR_DMSTATUS);
    assign control_wen = reg_bus.wen && sel_control;

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            dmactive  <= 1'b0;
            halt_req  <= 1'b0;
            hartreset <= 1'b0;
            ndmreset  <= 1'b0;
        end else if (control_wen) begin
            dmactive  <= wr_ctrl.dmactive;
            // writing dmactive low puts the module back into its reset state
            halt_req  <= wr_ctrl.haltreq & wr_ctrl.dmactive;
            hartreset <= wr_ctrl.hartreset & wr_ctrl.dmactive;
            ndmreset  <= wr_ctrl.ndmreset & wr_ctrl.dmactive;
        end
    end

    // havereset belongs to the hart, so it follows the core reset and not the DM reset
    always_ff @(posedge dm_clk or negedge dm_core_rst_n) begin
        if (!dm_core_rst_n) begin
            havereset <= 1'b1;
        end else if (control_wen && wr_ctrl.ackhavereset && wr_ctrl.dmactive) begin
            havereset <= 1'b0;
        end
    end

    always_comb begin
        control_rd           = '0;
        control_rd.haltreq   = halt_req;
        control_rd.hartreset = hartreset;
        control_rd.ndmreset  = ndmreset;
        control_rd.dmactive  = dmactive; // ackhavereset is write-only and reads zero
    end

    // with no hart-status inputs the hart is reported as running and never halted
    assign status_rd = {
        7'h0,
        ndmreset,             // 24
        4'h0,
        havereset, havereset, // allhavereset, anyhavereset
        6'h0,                 // resumeack and unavailable/nonexistent stay low
        2'b11,                // allrunning, anyrunning
        2'b00,                // allhalted, anyhalted
        1'b1,                 // authenticated
        3'b000,
        DM_VERSION
    };

    always_comb begin
        if (sel_control) begin
            reg_bus.rdata = control_rd;
        end else if (sel_status) begin
            reg_bus.rdata = status_rd;
        end else begin
            reg_bus.rdata = 32'h0;
        end
    end

    // dmstatus is read-only, every other address answers with failed status
    assign reg_bus.ok = (reg_bus.ren && (sel_control || sel_status)) || control_wen;

    a_active_gates_ctrl: assert property (
        @(posedge dm_clk) disable iff (!dm_rst_n)
        !dmactive |-> !halt_req && !hartreset
    ) else $error("halt_req or hartreset set while dmactive is low");

endmodule

// File: hdl/dmi_response.sv
`timescale 1ns/1ns

module dmi_response import dm_pkg::*; (
    input  logic             dm_clk,
    input  logic             dm_rst_n,
    input  logic             dm2dtm_full,
    output logic             dm2dtm_wen,
    output logic [DMI_W-1:0] dm2dtm_data_in,
    dm_reg_if.resp           reg_bus
);

    logic             strobe;
    logic [1:0]       status;
    logic [31:0]      resp_data;
    logic [DMI_W-1:0] resp_word;

    assign strobe = reg_bus.ren | reg_bus.wen | reg_bus.idle_op;
    assign status = reg_bus.ok ? RESP_OK : RESP_FAIL;

    // writes echo the request data, failed reads return zero
    assign resp_data = reg_bus.wen ? reg_bus.wdata.raw :
                       (reg_bus.ok ? reg_bus.rdata : 32'h0);

    assign resp_word = reg_bus.idle_op ? '0 : {reg_bus.addr, resp_data, status};

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            dm2dtm_wen     <= 1'b0;
            dm2dtm_data_in <= '0;
        end else begin
            dm2dtm_wen <= strobe; // the strobes are single cycle, so is the push
            if (strobe) begin
                dm2dtm_data_in <= resp_word; // held until the next response
            end
        end
    end

    // the return path has no back-pressure, a full FIFO here drops a response
    a_no_push_when_full: assert property (
        @(posedge dm_clk) disable iff (!dm_rst_n)
        dm2dtm_wen |-> !dm2dtm_full
    ) else $error("response written while the return FIFO is full");

endmodule

// File: hdl/dm_top.sv
`timescale 1ns/1ns

module dm_top import dm_pkg::*; (
    input  logic             dm_clk,
    input  logic             dm_rst_n,
    input  logic             dm_core_rst_n,

    output logic             halt_req,
    output logic             hartreset,
    output logic             ndmreset,

    input  logic             dm2dtm_full,
    output logic             dm2dtm_wen,
    output logic [DMI_W-1:0] dm2dtm_data_in,

    input  logic             dtm2dm_empty,
    output logic             dtm2dm_ren,
    input  logic [DMI_W-1:0] dtm2dm_data_out
);

    dm_reg_if reg_bus ();

    dmi_intake u_intake (
        .dm_clk          (dm_clk),
        .dm_rst_n        (dm_rst_n),
        .dtm2dm_empty    (dtm2dm_empty),
        .dtm2dm_data_out (dtm2dm_data_out),
        .dtm2dm_ren      (dtm2dm_ren),
        .reg_bus         (reg_bus.intake)
    );

    dm_regs u_regs (
        .dm_clk        (dm_clk),
        .dm_rst_n      (dm_rst_n),
        .dm_core_rst_n (dm_core_rst_n),
        .halt_req      (halt_req),
        .hartreset     (hartreset),
        .ndmreset      (ndmreset),
        .reg_bus       (reg_bus.regs)
    );

    dmi_response u_response (
        .dm_clk         (dm_clk),
        .dm_rst_n       (dm_rst_n),
        .dm2dtm_full    (dm2dtm_full),
        .dm2dtm_wen     (dm2dtm_wen),
        .dm2dtm_data_in (dm2dtm_data_in),
        .reg_bus        (reg_bus.resp)
    );

endmodule

// File: dv/dm_tb_table.svh
`ifndef DM_TB_TABLE_SVH
`define DM_TB_TABLE_SVH

// each row holds the test name, op, address, request data and expected response word,
// followed by the expected {halt_req, hartreset, ndmreset} after the response

string            row_name [$];
logic [1:0]       row_op   [$];
dmi_addr_t        row_addr [$];
logic [31:0]      row_data [$];
logic [DMI_W-1:0] row_exp  [$];
logic [2:0]       row_outs [$];

task automatic add_row(input string name, input logic [1:0] op, input dmi_addr_t addr,
                       input logic [31:0] data, input logic [DMI_W-1:0] exp_word,
                       input logic [2:0] exp_outs);
    row_name.push_back(name);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_exp.push_back(exp_word);
    row_outs.push_back(exp_outs);
endtask

task automatic load_table();
    add_row("status_reset", OP_READ, ADDR_DMSTATUS, 32'h0,
            dmi_word(ADDR_DMSTATUS, 32'h000c_0c82, RESP_OK), 3'b000);
    add_row("ctrl_wr_active", OP_WRITE, ADDR_DMCONTROL, 32'ha000_0003,
            dmi_word(ADDR_DMCONTROL, 32'ha000_0003, RESP_OK), 3'b111);
    add_row("ctrl_rd_active", OP_READ, ADDR_DMCONTROL, 32'h0,
            dmi_word(ADDR_DMCONTROL, 32'ha000_0003, RESP_OK), 3'b111);
    add_row("status_ndmreset", OP_READ, ADDR_DMSTATUS, 32'h0,
            dmi_word(ADDR_DMSTATUS, 32'h010c_0c82, RESP_OK), 3'b111);
    add_row("ctrl_wr_inactive", OP_WRITE, ADDR_DMCONTROL, 32'ha000_0002,
            dmi_word(ADDR_DMCONTROL, 32'ha000_0002, RESP_OK), 3'b000);
    add_row("ctrl_rd_inactive", OP_READ, ADDR_DMCONTROL, 32'h0,
            dmi_word(ADDR_DMCONTROL, 32'h0, RESP_OK), 3'b000);
    add_row("ack_havereset", OP_WRITE, ADDR_DMCONTROL, 32'h1000_0001,
            dmi_word(ADDR_DMCONTROL, 32'h1000_0001, RESP_OK), 3'b000);
    add_row("status_acked", OP_READ, ADDR_DMSTATUS, 32'h0,
            dmi_word(ADDR_DMSTATUS, 32'h0000_0c82, RESP_OK), 3'b000);
    add_row("rd_unmapped", OP_READ, 7'h04, 32'h1234_5678,
            dmi_word(7'h04, 32'h0, RESP_FAIL), 3'b000);
    add_row("rd_dropped_sbcs", OP_READ, 7'h38, 32'h0,
            dmi_word(7'h38, 32'h0, RESP_FAIL), 3'b000);
    add_row("wr_status", OP_WRITE, ADDR_DMSTATUS, 32'hdead_beef,
            dmi_word(ADDR_DMSTATUS, 32'hdead_beef, RESP_FAIL), 3'b000);
    add_row("nop", OP_NOP, ADDR_DMCONTROL, 32'hffff_ffff, '0, 3'b000);
    add_row("rsvd", OP_RSVD, ADDR_DMCONTROL, 32'ha000_0003, '0, 3'b000);
    add_row("ctrl_rd_after_nop", OP_READ, ADDR_DMCONTROL, 32'h0,
            dmi_word(ADDR_DMCONTROL, 32'h0000_0001, RESP_OK), 3'b000);
endtask

`endif

// File: dv/dm_tb.sv
`timescale 1ns/1ns

module dm_tb import dm_pkg::*; ();

    logic             dm_clk;
    logic             dm_rst_n;
    logic             dm_core_rst_n;
    logic             halt_req;
    logic             hartreset;
    logic             ndmreset;
    logic             dm2dtm_full;
    logic             dm2dtm_wen;
    logic [DMI_W-1:0] dm2dtm_data_in;
    logic             dtm2dm_empty;
    logic             dtm2dm_ren;
    logic [DMI_W-1:0] dtm2dm_data_out;

    integer seed = 32'hf896930b;
    int     gap;

    dm_top dut (.*);

    initial dm_clk = 1'b0;
    always #50 dm_clk = ~dm_clk;

    // request and response words share the {addr, data, op/status} layout
    function automatic logic [DMI_W-1:0] dmi_word(input dmi_addr_t addr,
                                                  input logic [31:0] data,
                                                  input logic [1:0] low);
        return {addr, data, low};
    endfunction

    `include "dm_tb_table.svh"

    task automatic stop_on_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    // inputs change and outputs are sampled 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge dm_clk);
        #10;
    endtask

    task automatic wait_pop(input string name);
        int n;
        n = 0;
        while (dtm2dm_ren !== 1'b1) begin
            check_value(name, "response before pop", 0, dm2dtm_wen);
            if (n == 20) begin
                $display("timeout: request %s was not popped within 20 cycles", name);
                stop_on_failure();
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic run_row(input int i);
        int lat;
        int exp_lat;
        exp_lat = (row_op[i] == OP_READ || row_op[i] == OP_WRITE) ? 3 : 2;
        dtm2dm_data_out = dmi_word(row_addr[i], row_data[i], row_op[i]);
        dtm2dm_empty    = 1'b0;
        wait_pop(row_name[i]);
        next_cycle();
        dtm2dm_empty = 1'b1; // the word left the FIFO at the pop edge
        check_value(row_name[i], "pop width", 0, dtm2dm_ren);
        lat = 1;
        while (dm2dtm_wen !== 1'b1) begin
            if (lat > 10) begin
                $display("timeout: no response for request %s within 10 cycles", row_name[i]);
                stop_on_failure();
            end
            next_cycle();
            lat++;
        end
        check_value(row_name[i], "latency", exp_lat, lat);
        check_value(row_name[i], "response word", row_exp[i], dm2dtm_data_in);
        check_value(row_name[i], "halt/hartreset/ndmreset", row_outs[i],
                    {halt_req, hartreset, ndmreset});
        next_cycle();
        check_value(row_name[i], "response width", 0, dm2dtm_wen);
    endtask

    initial begin
        dm_rst_n        = 1'b0;
        dm_core_rst_n   = 1'b0;
        dm2dtm_full     = 1'b0;
        dtm2dm_empty    = 1'b1;
        dtm2dm_data_out = '0;
        load_table();
        repeat (2) @(posedge dm_clk);
        #10;
        dm_rst_n      = 1'b1;
        dm_core_rst_n = 1'b1;
        next_cycle();
        check_value("reset", "halt/hartreset/ndmreset", 3'b000, {halt_req, hartreset, ndmreset});
        check_value("reset", "dtm2dm_ren", 0, dtm2dm_ren);
        check_value("reset", "dm2dtm_wen", 0, dm2dtm_wen);
        check_value("reset", "response word", 0, dm2dtm_data_in);
        for (int i = 0; i < row_name.size(); i++) begin
            run_row(i);
            gap = {$random(seed)} % 4; // FIFO stays empty for a while between requests
            repeat (gap) next_cycle();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: project.f
+incdir+dv
hdl/dm_pkg.sv
hdl/dm_reg_if.sv
hdl/dmi_intake.sv
hdl/dm_regs.sv
hdl/dmi_response.sv
hdl/dm_top.sv
dv/dm_tb.sv
